//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int PC_W    = 64;
    localparam int TAG_W   = 55;
    localparam int INDEX_W = 6;
    localparam int SETS    = 64;
    localparam int WAYS    = 8;
    localparam int WAY_W   = 3;
    localparam int PLRU_W  = 7;
    localparam int WORD_W  = 64;
    localparam int BANK_W  = 128;
    localparam int BANKS   = 4;

    // axi read channel codes
    localparam logic [3:0] AXI_ID      = 4'd0;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [2:0] SIZE_WORD   = 3'd2;
    localparam logic [2:0] SIZE_DWORD  = 3'd3;
    localparam logic [1:0] BURST_FIXED = 2'b00;

    // instruction type seen in decode
    typedef logic [2:0] id_type_t;
    localparam id_type_t TYPE_NOP     = 3'd0;
    localparam id_type_t TYPE_FENCE_I = 3'd5;

    typedef logic [3:0] trap_t;
    localparam trap_t TRAP_NOP            = 4'd0;
    localparam trap_t TRAP_TIMER_INT      = 4'd1;
    localparam trap_t TRAP_FETCH_MISALIGN = 4'd2;

    typedef enum logic [2:0] {
        ST_START  = 3'd0,
        ST_AR     = 3'd1,
        ST_R      = 3'd2,
        ST_FILL   = 3'd3,
        ST_FINISH = 3'd4
    } fetch_state_t;

    // csr bit positions
    localparam int MSTATUS_MIE_BIT = 3;
    localparam int MIE_MTIE_BIT    = 7;
    localparam int MIP_MTIP_BIT    = 7;

endpackage

`default_nettype wire

//--- fetch_trap_check.sv
`default_nettype none

module fetch_trap_check (
    input  wire logic [1:0]            pc,
    input  wire logic [63:0]           mstatus,
    input  wire logic [63:0]           mie,
    input  wire logic [63:0]           mip,
    input  wire icache_pkg::id_type_t  id_type,
    output icache_pkg::trap_t          trap
);

    logic timer_pending;

    // machine timer interrupt enabled globally and locally, and pending
    assign timer_pending = mstatus[icache_pkg::MSTATUS_MIE_BIT]
                         & mie[icache_pkg::MIE_MTIE_BIT]
                         & mip[icache_pkg::MIP_MTIP_BIT];

    always_comb begin
        trap = icache_pkg::TRAP_NOP;
        if (id_type == icache_pkg::TYPE_NOP) begin
            if (timer_pending) begin
                trap = icache_pkg::TRAP_TIMER_INT;
            end else if (pc != 2'b00) begin
                trap = icache_pkg::TRAP_FETCH_MISALIGN;
            end
        end
    end

endmodule

`default_nettype wire

//--- tag_array.sv
`default_nettype none

module tag_array (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic [icache_pkg::INDEX_W-1:0]   set_index,
    input  wire logic [icache_pkg::TAG_W-1:0]     pc_tag,
    input  wire logic [icache_pkg::WAY_W-1:0]     victim_way,
    input  wire logic                             fill_en,
    input  wire logic                             flush,
    output logic      [icache_pkg::WAYS-1:0]      way_hit,
    output logic      [icache_pkg::WAY_W-1:0]     fill_way
);

    logic [icache_pkg::WAYS-1:0]  valid [icache_pkg::SETS];
    logic [icache_pkg::TAG_W-1:0] tags  [icache_pkg::WAYS][icache_pkg::SETS];

    // compare all ways of the indexed set
    always_comb begin
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            way_hit[w] = valid[set_index][w] && (tags[w][set_index] == pc_tag);
        end
    end

    // lowest invalid way first, plru victim once the set is full
    always_comb begin
        fill_way = victim_way;
        for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
            if (!valid[set_index][w]) begin
                fill_way = w[icache_pkg::WAY_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '{default: '0};
        end else if (fill_en) begin
            valid[set_index][fill_way] <= 1'b1;
        end else if (flush) begin
            valid <= '{default: '0};
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_way][set_index] <= pc_tag;
        end
    end

endmodule

`default_nettype wire

//--- plru_tree.sv
`default_nettype none

module plru_tree (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic [icache_pkg::INDEX_W-1:0]   set_index,
    input  wire logic [icache_pkg::WAYS-1:0]      way_hit,
    input  wire logic                             lookup_en,
    output logic      [icache_pkg::WAY_W-1:0]     victim_way
);

    logic [icache_pkg::PLRU_W-1:0] tree [icache_pkg::SETS];
    logic [icache_pkg::PLRU_W-1:0] cur_bits;
    logic [icache_pkg::PLRU_W-1:0] upd_bits;
    logic [icache_pkg::WAY_W-1:0]  hit_way;
    logic                          hit;

    assign cur_bits = tree[set_index];
    assign hit      = |way_hit;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = w[icache_pkg::WAY_W-1:0];
            end
        end
    end

    // root, then level two, then the pair bit; each points away from the hit way
    always_comb begin
        upd_bits = cur_bits;
        upd_bits[0] = ~hit_way[2];
        upd_bits[1 + hit_way[2]] = ~hit_way[1];
        upd_bits[3 + hit_way[2:1]] = ~hit_way[0];
    end

    always_comb begin
        victim_way[2] = cur_bits[0];
        victim_way[1] = cur_bits[1 + victim_way[2]];
        victim_way[0] = cur_bits[3 + victim_way[2:1]];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tree <= '{default: '0};
        end else if (lookup_en && hit) begin
            tree[set_index] <= upd_bits;
        end
    end

endmodule

`default_nettype wire

//--- refill_ctrl.sv
`default_nettype none

module refill_ctrl (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [31:0]                   pc,
    input  wire icache_pkg::id_type_t          id_type,
    input  wire icache_pkg::trap_t             trap,
    input  wire logic [icache_pkg::WAYS-1:0]   way_hit,
    input  wire logic                          if2_ready,
    input  wire logic                          cd_trap,
    input  wire logic                          arready,
    input  wire logic                          rvalid,
    input  wire logic [1:0]                    rresp,
    input  wire logic [icache_pkg::WORD_W-1:0] rdata,
    input  wire logic                          rlast,
    input  wire logic [3:0]                    rid,
    output logic                               ready,
    output logic                               valid_out,
    output logic      [icache_pkg::WORD_W-1:0] fetch_data,
    output logic                               lookup_en,
    output logic                               fill_en,
    output logic                               flush,
    output logic      [icache_pkg::WORD_W-1:0] fill_data,
    output logic                               arvalid,
    output logic      [31:0]                   araddr,
    output logic      [3:0]                    arid,
    output logic      [7:0]                    arlen,
    output logic      [2:0]                    arsize,
    output logic      [1:0]                    arburst,
    output logic                               rready
);

    icache_pkg::fetch_state_t state;
    icache_pkg::fetch_state_t state_next;

    logic [icache_pkg::WORD_W-1:0] data_q;
    logic uncached;
    logic hit;
    logic beat_ok;
    logic start_ok;

    // the upper half of the 32-bit space is cacheable
    assign uncached = ~pc[31];
    assign hit      = |way_hit;
    assign start_ok = (trap == icache_pkg::TRAP_NOP) && (id_type == icache_pkg::TYPE_NOP)
                    && !cd_trap;
    assign beat_ok  = rvalid && rlast && (rid == icache_pkg::AXI_ID)
                    && (rresp == icache_pkg::RESP_OKAY || rresp == icache_pkg::RESP_EXOKAY);

    assign lookup_en = (state == icache_pkg::ST_START) && start_ok;
    assign fill_en   = (state == icache_pkg::ST_FILL);
    assign flush     = (id_type == icache_pkg::TYPE_FENCE_I) && (state != icache_pkg::ST_FILL);
    assign fill_data = data_q;

    assign arvalid = (state == icache_pkg::ST_AR);
    assign rready  = (state == icache_pkg::ST_R);
    assign arid    = icache_pkg::AXI_ID;
    assign arlen   = 8'd0;
    assign arburst = icache_pkg::BURST_FIXED;
    assign araddr  = uncached ? pc : {pc[31:3], 3'b000};
    assign arsize  = uncached ? icache_pkg::SIZE_WORD : icache_pkg::SIZE_DWORD;

    assign fetch_data = (state == icache_pkg::ST_R) ? rdata : data_q;

    always_comb begin
        state_next = state;
        ready      = 1'b0;
        valid_out  = 1'b0;
        case (state)
            icache_pkg::ST_START: begin
                if (!start_ok) begin
                    ready = 1'b1;
                end else if (!uncached && hit) begin
                    ready     = if2_ready;
                    valid_out = 1'b1;
                end else begin
                    state_next = icache_pkg::ST_AR;
                end
            end
            icache_pkg::ST_AR: begin
                if (arready) begin
                    state_next = icache_pkg::ST_R;
                end
            end
            icache_pkg::ST_R: begin
                if (beat_ok) begin
                    if (uncached) begin
                        ready     = cd_trap | if2_ready;
                        valid_out = ~cd_trap;
                        if (if2_ready || cd_trap) begin
                            state_next = icache_pkg::ST_START;
                        end else begin
                            state_next = icache_pkg::ST_FINISH;
                        end
                    end else if (cd_trap) begin
                        // redirected, drop the line
                        state_next = icache_pkg::ST_START;
                    end else begin
                        state_next = icache_pkg::ST_FILL;
                    end
                end
            end
            icache_pkg::ST_FILL: begin
                state_next = icache_pkg::ST_START;
            end
            icache_pkg::ST_FINISH: begin
                ready     = cd_trap | if2_ready;
                valid_out = ~cd_trap;
                if (if2_ready || cd_trap) begin
                    state_next = icache_pkg::ST_START;
                end
            end
            default: begin
                state_next = icache_pkg::ST_START;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= icache_pkg::ST_START;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == icache_pkg::ST_R && beat_ok) begin
            data_q <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- bank_write.sv
`default_nettype none

module bank_write (
    input  wire logic                                                fill_en,
    input  wire logic [icache_pkg::WAY_W-1:0]                        fill_way,
    input  wire logic [icache_pkg::WORD_W-1:0]                       fill_data,
    output logic      [icache_pkg::BANKS-1:0]                        sram_wen,
    output logic      [icache_pkg::BANKS-1:0][icache_pkg::BANK_W-1:0] sram_wmask,
    output logic      [icache_pkg::BANKS-1:0][icache_pkg::BANK_W-1:0] sram_wdata
);

    logic [icache_pkg::BANKS-1:0] bank_sel;

    // two ways per bank, way w lives in bank w/2
    assign bank_sel = fill_en ? (icache_pkg::BANKS'(1) << fill_way[icache_pkg::WAY_W-1:1]) : '0;

    always_comb begin
        for (int b = 0; b < icache_pkg::BANKS; b++) begin
            sram_wen[b]   = 1'b1;
            sram_wmask[b] = '1;
            sram_wdata[b] = '0;
            if (bank_sel[b]) begin
                sram_wen[b] = 1'b0;
                if (fill_way[0]) begin
                    // odd way takes the upper doubleword
                    sram_wmask[b] = {{icache_pkg::WORD_W{1'b0}}, {icache_pkg::WORD_W{1'b1}}};
                    sram_wdata[b] = {fill_data, {icache_pkg::WORD_W{1'b0}}};
                end else begin
                    sram_wmask[b] = {{icache_pkg::WORD_W{1'b1}}, {icache_pkg::WORD_W{1'b0}}};
                    sram_wdata[b] = {{icache_pkg::WORD_W{1'b0}}, fill_data};
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ifu_icache.sv
`default_nettype none

module ifu_icache (
    input  wire logic                                                clk,
    input  wire logic                                                rst,
    input  wire logic [icache_pkg::PC_W-1:0]                         pc,
    input  wire logic [63:0]                                         mstatus,
    input  wire logic [63:0]                                         mie,
    input  wire logic [63:0]                                         mip,
    input  wire icache_pkg::id_type_t                                id_type,
    input  wire logic                                                if2_ready,
    input  wire logic                                                cd_trap,
    input  wire logic                                                arready,
    output logic                                                     arvalid,
    output logic      [31:0]                                         araddr,
    output logic      [3:0]                                          arid,
    output logic      [7:0]                                          arlen,
    output logic      [2:0]                                          arsize,
    output logic      [1:0]                                          arburst,
    output logic                                                     rready,
    input  wire logic                                                rvalid,
    input  wire logic [1:0]                                          rresp,
    input  wire logic [icache_pkg::WORD_W-1:0]                       rdata,
    input  wire logic                                                rlast,
    input  wire logic [3:0]                                          rid,
    output icache_pkg::trap_t                                        trap,
    output logic                                                     valid_out,
    output logic                                                     ready,
    output logic      [icache_pkg::WORD_W-1:0]                       fetch_data,
    output logic      [icache_pkg::WAYS-1:0]                         way_hit,
    output logic      [icache_pkg::INDEX_W-1:0]                      sram_addr,
    output logic      [icache_pkg::BANKS-1:0]                        sram_wen,
    output logic      [icache_pkg::BANKS-1:0][icache_pkg::BANK_W-1:0] sram_wmask,
    output logic      [icache_pkg::BANKS-1:0][icache_pkg::BANK_W-1:0] sram_wdata
);

    logic [icache_pkg::INDEX_W-1:0] set_index;
    logic [icache_pkg::TAG_W-1:0]   pc_tag;
    logic [icache_pkg::WAY_W-1:0]   victim_way;
    logic [icache_pkg::WAY_W-1:0]   fill_way;
    logic [icache_pkg::WORD_W-1:0]  fill_data;
    logic lookup_en;
    logic fill_en;
    logic flush;

    // tag | index | 3-bit doubleword offset
    assign set_index = pc[3 +: icache_pkg::INDEX_W];
    assign pc_tag    = pc[icache_pkg::PC_W-1 -: icache_pkg::TAG_W];
    assign sram_addr = set_index;

    fetch_trap_check u_fetch_trap_check (
        .pc      (pc[1:0]),
        .mstatus (mstatus),
        .mie     (mie),
        .mip     (mip),
        .id_type (id_type),
        .trap    (trap)
    );

    tag_array u_tag_array (
        .clk        (clk),
        .rst        (rst),
        .set_index  (set_index),
        .pc_tag     (pc_tag),
        .victim_way (victim_way),
        .fill_en    (fill_en),
        .flush      (flush),
        .way_hit    (way_hit),
        .fill_way   (fill_way)
    );

    plru_tree u_plru_tree (
        .clk        (clk),
        .rst        (rst),
        .set_index  (set_index),
        .way_hit    (way_hit),
        .lookup_en  (lookup_en),
        .victim_way (victim_way)
    );

    refill_ctrl u_refill_ctrl (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc[31:0]),
        .id_type    (id_type),
        .trap       (trap),
        .way_hit    (way_hit),
        .if2_ready  (if2_ready),
        .cd_trap    (cd_trap),
        .arready    (arready),
        .rvalid     (rvalid),
        .rresp      (rresp),
        .rdata      (rdata),
        .rlast      (rlast),
        .rid        (rid),
        .ready      (ready),
        .valid_out  (valid_out),
        .fetch_data (fetch_data),
        .lookup_en  (lookup_en),
        .fill_en    (fill_en),
        .flush      (flush),
        .fill_data  (fill_data),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arid       (arid),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .rready     (rready)
    );

    bank_write u_bank_write (
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_data  (fill_data),
        .sram_wen   (sram_wen),
        .sram_wmask (sram_wmask),
        .sram_wdata (sram_wdata)
    );

endmodule

`default_nettype wire

//--- tb_ifu_icache.sv
`default_nettype none

module tb_ifu_icache;

    localparam int         TRAP_ROUNDS      = 40;
    localparam int         COLD_PAIRS       = 16;
    localparam int         PLRU_FETCHES     = 120;
    localparam int         UNCACHED_FETCHES = 24;
    localparam int         FENCE_PCS        = 8;
    localparam int         REDIRECT_PAIRS   = 8;
    // trap rounds and the fence cycle count as one fetch each
    localparam int         FETCHES  = TRAP_ROUNDS + 2 * COLD_PAIRS + PLRU_FETCHES
                                    + UNCACHED_FETCHES + 3 * FENCE_PCS + 1
                                    + 2 * REDIRECT_PAIRS;
    localparam longint     TIMEOUT  = longint'(FETCHES) * 2000 * 100;
    localparam logic [2:0] ID_OTHER = 3'd1;

    logic        clk;
    logic        rst;
    logic [63:0] pc;
    logic [63:0] mstatus;
    logic [63:0] mie;
    logic [63:0] mip;
    logic [2:0]  id_type;
    logic        if2_ready;
    logic        cd_trap;
    logic        arready;
    logic        arvalid;
    logic [31:0] araddr;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rready;
    logic        rvalid;
    logic [1:0]  rresp;
    logic [63:0] rdata;
    logic        rlast;
    logic [3:0]  rid;
    logic [3:0]  trap;
    logic        valid_out;
    logic        ready;
    logic [63:0] fetch_data;
    logic [7:0]  way_hit;
    logic [5:0]  sram_addr;
    logic [3:0]  sram_wen;
    logic [3:0][127:0] sram_wmask;
    logic [3:0][127:0] sram_wdata;

    integer seed;

    // reference model of the tag store and replacement trees
    logic                          m_valid [icache_pkg::SETS][icache_pkg::WAYS];
    logic [icache_pkg::TAG_W-1:0]  m_tag   [icache_pkg::SETS][icache_pkg::WAYS];
    logic [icache_pkg::PLRU_W-1:0] m_plru  [icache_pkg::SETS];

    ifu_icache u_ifu_icache (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Testbench failed");
        $fatal(1, "watchdog expired before the fetch sequence completed");
    end

    task automatic check_eq(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic int pick(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [63:0] rand64();
        rand64 = {$random(seed), $random(seed)};
    endfunction

    // cacheable aligned pc, in the given set unless set is negative
    function automatic logic [63:0] cached_pc(input int set);
        logic [63:0] p;
        p = rand64();
        p[31] = 1'b1;
        p[1:0] = 2'b00;
        if (set >= 0) begin
            p[8:3] = 6'(set);
        end
        return p;
    endfunction

    function automatic logic [63:0] uncached_pc();
        logic [63:0] p;
        p = rand64();
        p[31] = 1'b0;
        p[1:0] = 2'b00;
        return p;
    endfunction

    function automatic logic [3:0] expected_trap(input logic [63:0] p, input logic [63:0] ms,
                                                 input logic [63:0] me, input logic [63:0] mp,
                                                 input logic [2:0] t);
        if (t != icache_pkg::TYPE_NOP) begin
            return icache_pkg::TRAP_NOP;
        end
        if (ms[icache_pkg::MSTATUS_MIE_BIT] && me[icache_pkg::MIE_MTIE_BIT]
            && mp[icache_pkg::MIP_MTIP_BIT]) begin
            return icache_pkg::TRAP_TIMER_INT;
        end
        if (p[1:0] != 2'b00) begin
            return icache_pkg::TRAP_FETCH_MISALIGN;
        end
        return icache_pkg::TRAP_NOP;
    endfunction

    function automatic int hit_way_of(input logic [63:0] p);
        int s;
        int found;
        s = int'(p[8:3]);
        found = -1;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == p[63:9]) begin
                found = w;
            end
        end
        return found;
    endfunction

    // heap order walk where node n has children 2n+1 and 2n+2 and leaves 7..14 are the ways
    function automatic int victim_of(input int s);
        int node;
        node = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            node = 2 * node + 1 + int'(m_plru[s][node]);
        end
        return node - 7;
    endfunction

    function automatic void touch_plru(input int s, input int w);
        int node;
        int dir;
        node = 0;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            dir = (w >> lvl) & 1;
            m_plru[s][node] = (dir == 0);
            node = 2 * node + 1 + dir;
        end
    endfunction

    function automatic int fill_way_of(input int s);
        int way;
        way = victim_of(s);
        for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
            if (!m_valid[s][w]) begin
                way = w;
            end
        end
        return way;
    endfunction

    function automatic void clear_valid();
        for (int s = 0; s < icache_pkg::SETS; s++) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
    endfunction

    task automatic quiet_bus();
        arready = 1'b0;
        rvalid = 1'b0;
        rid = icache_pkg::AXI_ID;
        rlast = 1'b0;
        rresp = icache_pkg::RESP_OKAY;
        cd_trap = 1'b0;
    endtask

    task automatic trap_round();
        logic [3:0] exp;
        @(negedge clk);
        quiet_bus();
        pc = rand64();
        mstatus = rand64();
        mie = rand64();
        mip = rand64();
        id_type = 3'(pick(8));
        if2_ready = (pick(2) == 1);
        exp = expected_trap(pc, mstatus, mie, mip, id_type);
        // a clean nop would start a fetch so this round is kept idle
        if (id_type == icache_pkg::TYPE_NOP && exp == icache_pkg::TRAP_NOP) begin
            id_type = ID_OTHER;
        end
        #1;
        check_eq("trap code", 128'(exp), 128'(trap));
        check_eq("trap ready", 128'(1), 128'(ready));
        check_eq("trap valid_out", 128'(0), 128'(valid_out));
        // a started read would show as arvalid after the next edge
        @(posedge clk);
        #1;
        check_eq("trap arvalid", 128'(0), 128'(arvalid));
        if (id_type == icache_pkg::TYPE_FENCE_I) begin
            clear_valid();
        end
    endtask

    task automatic fence_cycle();
        @(negedge clk);
        quiet_bus();
        id_type = icache_pkg::TYPE_FENCE_I;
        #1;
        check_eq("fence ready", 128'(1), 128'(ready));
        check_eq("fence valid_out", 128'(0), 128'(valid_out));
        clear_valid();
    endtask

    task automatic address_phase(input logic [63:0] p);
        int d;
        d = pick(4);
        for (int i = 0; i <= d; i++) begin
            @(negedge clk);
            arready = (i == d);
            #1;
            check_eq("arvalid", 128'(1), 128'(arvalid));
            if (p[31]) begin
                check_eq("cached araddr", 128'({p[31:3], 3'b000}), 128'(araddr));
                check_eq("cached arsize", 128'(3), 128'(arsize));
            end else begin
                check_eq("uncached araddr", 128'(p[31:0]), 128'(araddr));
                check_eq("uncached arsize", 128'(2), 128'(arsize));
            end
            check_eq("arlen", 128'(0), 128'(arlen));
            check_eq("arid", 128'(0), 128'(arid));
            check_eq("arburst", 128'(0), 128'(arburst));
        end
    endtask

    task automatic fill_check(input logic [63:0] p, input logic [63:0] data);
        int s;
        int w;
        logic [3:0]   wen_exp;
        logic [127:0] mask_exp;
        logic [127:0] data_exp;
        s = int'(p[8:3]);
        w = fill_way_of(s);
        wen_exp = ~(4'b0001 << (w / 2));
        @(negedge clk);
        quiet_bus();
        #1;
        check_eq("fill sram_addr", 128'(s), 128'(sram_addr));
        check_eq("fill sram_wen", 128'(wen_exp), 128'(sram_wen));
        for (int b = 0; b < icache_pkg::BANKS; b++) begin
            mask_exp = '1;
            data_exp = '0;
            if (b == w / 2 && w % 2 == 1) begin
                mask_exp = {64'h0, {64{1'b1}}};
                data_exp = {data, 64'h0};
            end else if (b == w / 2) begin
                mask_exp = {{64{1'b1}}, 64'h0};
                data_exp = {64'h0, data};
            end
            check_eq("fill sram_wmask", mask_exp, sram_wmask[b]);
            check_eq("fill sram_wdata", data_exp, sram_wdata[b]);
        end
        m_valid[s][w] = 1'b1;
        m_tag[s][w] = p[63:9];
    endtask

    task automatic read_phase(input logic [63:0] p, input bit redirect, input bit hold);
        int d;
        int n;
        logic [63:0] data;
        d = pick(4);
        data = '0;
        for (int i = 0; i <= d + 1; i++) begin
            @(negedge clk);
            quiet_bus();
            rlast = 1'b1;
            rdata = rand64();
            if (i == d && pick(2) == 1) begin
                // a beat the stage has to ignore
                rvalid = 1'b1;
                case (pick(3))
                    0: rid = 4'(1 + pick(15));
                    1: rresp = 2'b10;
                    default: rlast = 1'b0;
                endcase
            end
            if (i == d + 1) begin
                rvalid = 1'b1;
                rresp = (pick(2) == 1) ? icache_pkg::RESP_EXOKAY : icache_pkg::RESP_OKAY;
                cd_trap = redirect;
                if2_ready = !hold;
                data = rdata;
            end
            #1;
            check_eq("rready", 128'(1), 128'(rready));
            check_eq("read sram_wen", 128'(4'hf), 128'(sram_wen));
            if (i <= d) begin
                check_eq("valid_out before beat", 128'(0), 128'(valid_out));
            end
        end
        if (p[31]) begin
            check_eq("cached beat valid_out", 128'(0), 128'(valid_out));
            check_eq("cached beat ready", 128'(0), 128'(ready));
        end else begin
            check_eq("uncached beat valid_out", 128'(!redirect), 128'(valid_out));
            check_eq("uncached beat ready", 128'(redirect || !hold), 128'(ready));
            if (!redirect) begin
                check_eq("uncached fetch_data", 128'(data), 128'(fetch_data));
            end
        end
        if (redirect) begin
            @(negedge clk);
            quiet_bus();
            id_type = ID_OTHER;
            #1;
            check_eq("redirect sram_wen", 128'(4'hf), 128'(sram_wen));
            check_eq("redirect arvalid", 128'(0), 128'(arvalid));
            check_eq("redirect valid_out", 128'(0), 128'(valid_out));
        end else if (p[31]) begin
            fill_check(p, data);
        end else if (hold) begin
            n = 1 + pick(3);
            for (int i = 0; i <= n; i++) begin
                @(negedge clk);
                quiet_bus();
                if2_ready = (i == n);
                #1;
                check_eq("held valid_out", 128'(1), 128'(valid_out));
                check_eq("held fetch_data", 128'(data), 128'(fetch_data));
                check_eq("held ready", 128'(if2_ready), 128'(ready));
            end
        end
    endtask

    task automatic do_fetch(input logic [63:0] p, input bit redirect, input bit hold);
        int s;
        int hw;
        s = int'(p[8:3]);
        hw = p[31] ? hit_way_of(p) : -1;
        @(negedge clk);
        quiet_bus();
        pc = p;
        id_type = icache_pkg::TYPE_NOP;
        mstatus = '0;
        mie = '0;
        mip = '0;
        if2_ready = (pick(2) == 1);
        #1;
        check_eq("lookup trap", 128'(icache_pkg::TRAP_NOP), 128'(trap));
        if (hw >= 0) begin
            check_eq("hit valid_out", 128'(1), 128'(valid_out));
            check_eq("hit way_hit", 128'(1 << hw), 128'(way_hit));
            check_eq("hit ready", 128'(if2_ready), 128'(ready));
            touch_plru(s, hw);
        end else begin
            check_eq("miss valid_out", 128'(0), 128'(valid_out));
            check_eq("miss way_hit", 128'(0), 128'(way_hit));
            check_eq("miss ready", 128'(0), 128'(ready));
            address_phase(p);
            read_phase(p, redirect, hold);
        end
    endtask

    initial begin
        logic [63:0] p;
        logic [63:0] fence_pcs [FENCE_PCS];
        logic [63:0] hist [$];
        seed = 39002;
        rst = 1'b1;
        pc = '0;
        mstatus = '0;
        mie = '0;
        mip = '0;
        id_type = ID_OTHER;
        if2_ready = 1'b1;
        rdata = '0;
        quiet_bus();
        clear_valid();
        for (int s = 0; s < icache_pkg::SETS; s++) begin
            m_plru[s] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_eq("reset arvalid", 128'(0), 128'(arvalid));
        check_eq("reset rready", 128'(0), 128'(rready));
        check_eq("reset valid_out", 128'(0), 128'(valid_out));
        check_eq("reset sram_wen", 128'(4'hf), 128'(sram_wen));
        rst = 1'b0;

        repeat (TRAP_ROUNDS) trap_round();

        // cold misses followed by hits
        repeat (COLD_PAIRS) begin
            p = cached_pc(-1);
            do_fetch(p, 1'b0, 1'b0);
            do_fetch(p, 1'b0, 1'b0);
        end

        // overflow three sets so the tree picks victims
        repeat (PLRU_FETCHES) begin
            if (hist.size() > 0 && pick(5) < 2) begin
                p = hist[pick(hist.size())];
            end else begin
                p = cached_pc(2 + 21 * pick(3));
                hist.push_back(p);
            end
            do_fetch(p, 1'b0, 1'b0);
        end

        repeat (UNCACHED_FETCHES) do_fetch(uncached_pc(), 1'b0, pick(2) == 1);

        for (int k = 0; k < FENCE_PCS; k++) begin
            fence_pcs[k] = cached_pc(-1);
            do_fetch(fence_pcs[k], 1'b0, 1'b0);
            do_fetch(fence_pcs[k], 1'b0, 1'b0);
        end
        fence_cycle();
        for (int k = 0; k < FENCE_PCS; k++) begin
            do_fetch(fence_pcs[k], 1'b0, 1'b0);
        end

        repeat (REDIRECT_PAIRS) begin
            p = (pick(2) == 1) ? cached_pc(-1) : uncached_pc();
            do_fetch(p, 1'b1, 1'b0);
            do_fetch(p, 1'b0, 1'b0);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
icache_pkg.sv
fetch_trap_check.sv
tag_array.sv
plru_tree.sv
refill_ctrl.sv
bank_write.sv
ifu_icache.sv
tb_ifu_icache.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -f compile.f --top-module tb_ifu_icache -o tb_ifu_icache

./obj_dir/tb_ifu_icache
